// File: files.f
src/mips_ex_pkg.sv
src/operand_forward.sv
src/alu.sv
src/branch_dest_unit.sv
src/ex_stage_reg.sv
src/ex_stage.sv
verif/ex_stage_tb.sv

// File: src/alu.sv
`timescale 1ns/10ps

module alu (
	input  mips_ex_pkg::alu_op_t              op,
	input  logic [mips_ex_pkg::data_w-1:0]    a,
	input  logic [mips_ex_pkg::data_w-1:0]    b,
	output logic [mips_ex_pkg::data_w-1:0]    result,
	output logic                              zero
);
	import mips_ex_pkg::*;

	localparam int half_w = data_w / 2;

	logic [reg_idx_w-1:0] sh;     // shift distance
	logic                 lt_s;   // signed a < b
	logic                 lt_u;   // unsigned a < b

	assign sh   = a[reg_idx_w-1:0];   // only low five bits count
	assign lt_s = $signed(a) < $signed(b);
	assign lt_u = a < b;

	//////////////////////////////
	// operation mux
	//////////////////////////////

	always_comb
	begin
		case (op)
			alu_add:
			begin
				result = a + b;   // no overflow trap here
			end
			alu_sub:
			begin
				result = a - b;
			end
			alu_and:
			begin
				result = a & b;
			end
			alu_or:
			begin
				result = a | b;
			end
			alu_xor:
			begin
				result = a ^ b;
			end
			alu_nor:
			begin
				result = ~(a | b);
			end
			alu_slt:
			begin
				result = {{(data_w-1){1'b0}}, lt_s};
			end
			alu_sltu:
			begin
				result = {{(data_w-1){1'b0}}, lt_u};
			end
			// shifts move b, a holds the amount
			alu_sll:
			begin
				result = b << sh;
			end
			alu_srl:
			begin
				result = b >> sh;
			end
			alu_sra:
			begin
				result = $unsigned($signed(b) >>> sh);   // keeps sign bit
			end
			alu_lui:
			begin
				result = {b[half_w-1:0], {half_w{1'b0}}};
			end
			default:
			begin
				result = '0;   // unused codes
			end
		endcase
	end

	assign zero = (result == '0);   // for beq/bne, resolved elsewhere

endmodule

// File: src/branch_dest_unit.sv
`timescale 1ns/10ps

module branch_dest_unit (
	input  mips_ex_pkg::ex_req_t                 req,
	output logic [mips_ex_pkg::data_w-1:0]       branch_target,
	output logic [mips_ex_pkg::reg_idx_w-1:0]    write_reg
);
	import mips_ex_pkg::*;

	//////////////////////////////
	// branch target
	//////////////////////////////

	// pc already points past the branch, imm counts words
	assign branch_target = req.pc + req.imm;

	//////////////////////////////
	// destination register
	//////////////////////////////

	always_comb
	begin
		if (req.ex.link)
		begin
			write_reg = reg_idx_w'(link_reg);   // return address
		end
		else if (req.ex.dst_rd)
		begin
			write_reg = req.rd;   // r-type
		end
		else
		begin
			write_reg = req.rt;   // i-type, loads
		end
	end

endmodule

// File: src/ex_stage.sv
`timescale 1ns/10ps

module ex_stage (
	input  logic                       clk,
	input  logic                       reset,
	// from decode
	input  mips_ex_pkg::ex_req_t       in_req,
	input  logic                       in_valid,
	output logic                       in_ready,
	// bypass sources
	input  mips_ex_pkg::fwd_src_t      fwd_mem,
	input  mips_ex_pkg::fwd_src_t      fwd_wb,
	input  logic                       flush,
	// to mem
	output mips_ex_pkg::ex_result_t    out_res,
	output logic                       out_valid,
	input  logic                       out_ready
);
	import mips_ex_pkg::*;

	logic [data_w-1:0]    op_a;
	logic [data_w-1:0]    op_b;
	logic [data_w-1:0]    store_data;
	logic [data_w-1:0]    alu_result;
	logic                 zero;
	logic [data_w-1:0]    branch_target;
	logic [reg_idx_w-1:0] write_reg;

	//////////////////////////////
	// operand path
	//////////////////////////////

	operand_forward u_operand_forward (
		.req        (in_req),
		.fwd_mem    (fwd_mem),
		.fwd_wb     (fwd_wb),
		.op_a       (op_a),
		.op_b       (op_b),
		.store_data (store_data)
	);

	alu u_alu (
		.op     (in_req.ex.alu_op),
		.a      (op_a),
		.b      (op_b),
		.result (alu_result),
		.zero   (zero)
	);

	//////////////////////////////
	// branch / dest path
	//////////////////////////////

	branch_dest_unit u_branch_dest_unit (
		.req           (in_req),
		.branch_target (branch_target),
		.write_reg     (write_reg)
	);

	// both paths meet here, one cycle
	ex_stage_reg u_ex_stage_reg (
		.clk           (clk),
		.reset         (reset),
		.flush         (flush),
		.alu_result    (alu_result),
		.store_data    (store_data),
		.zero          (zero),
		.branch_target (branch_target),
		.write_reg     (write_reg),
		.req           (in_req),
		.in_valid      (in_valid),
		.in_ready      (in_ready),
		.out_res       (out_res),
		.out_valid     (out_valid),
		.out_ready     (out_ready)
	);

endmodule

// File: src/ex_stage_reg.sv
`timescale 1ns/10ps

module ex_stage_reg (
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic                                 flush,
	// operand path
	input  logic [mips_ex_pkg::data_w-1:0]       alu_result,
	input  logic [mips_ex_pkg::data_w-1:0]       store_data,
	input  logic                                 zero,
	// branch / destination path
	input  logic [mips_ex_pkg::data_w-1:0]       branch_target,
	input  logic [mips_ex_pkg::reg_idx_w-1:0]    write_reg,
	// request for the pass-through fields
	input  mips_ex_pkg::ex_req_t                 req,
	input  logic                                 in_valid,
	output logic                                 in_ready,
	// toward mem
	output mips_ex_pkg::ex_result_t              out_res,
	output logic                                 out_valid,
	input  logic                                 out_ready
);
	import mips_ex_pkg::*;

	ex_result_t next_res;   // result being offered this cycle

	//////////////////////////////
	// result assembly
	//////////////////////////////

	always_comb
	begin
		next_res.branch_target = branch_target;
		next_res.alu_result    = alu_result;
		next_res.zero          = zero;
		next_res.store_data    = store_data;
		next_res.write_reg     = write_reg;
		next_res.mem           = req.mem;    // untouched
		next_res.wb            = req.wb;     // untouched
		next_res.halt          = req.halt;
	end

	// empty, or the current item leaves this edge
	assign in_ready = !out_valid || out_ready;

	//////////////////////////////
	// stage register
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset || flush)
		begin
			out_valid <= 1'b0;
			out_res   <= '0;   // flushed item dropped with its payload
		end
		else if (in_ready)
		begin
			out_valid <= in_valid;
			if (in_valid)
			begin
				out_res <= next_res;   // accept
			end
		end
		// else stall, hold everything
	end

	// mem sees a steady item while it stalls us
	a_hold_on_stall: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready && !flush |=> out_valid && $stable(out_res))
		else $error("ex_stage_reg: result changed under back-pressure");

	// flushed item never reaches mem
	a_flush_clears: assert property (@(posedge clk)
		flush |=> !out_valid)
		else $error("ex_stage_reg: out_valid high after flush");

endmodule

// File: src/mips_ex_pkg.sv
package mips_ex_pkg;

	//////////////////////////////
	// widths
	//////////////////////////////

	localparam int data_w     = 32;   // datapath width, fixed by the isa
	localparam int reg_idx_w  = 5;    // 32 architectural registers
	localparam int link_reg   = 31;   // jal / jalr write $ra
	localparam int mem_ctrl_w = 9;    // memory control bus, opaque here

	//////////////////////////////
	// alu operation codes
	//////////////////////////////

	typedef enum logic [3:0] {
		alu_add  = 4'd0,
		alu_sub  = 4'd1,
		alu_and  = 4'd2,
		alu_or   = 4'd3,
		alu_xor  = 4'd4,
		alu_nor  = 4'd5,
		alu_slt  = 4'd6,   // signed compare
		alu_sltu = 4'd7,   // unsigned compare
		alu_sll  = 4'd8,
		alu_srl  = 4'd9,
		alu_sra  = 4'd10,
		alu_lui  = 4'd11   // imm to upper half
	} alu_op_t;

	//////////////////////////////
	// control and payload
	//////////////////////////////

	typedef struct packed {
		alu_op_t alu_op;
		logic    use_imm;     // b = sign-extended imm
		logic    use_shamt;   // a = zero-extended shamt
		logic    link;        // a = pc, b = 1
		logic    dst_rd;      // write rd, else rt
	} ex_ctrl_t;

	typedef logic [mem_ctrl_w-1:0] mem_ctrl_t;   // carried to mem stage untouched

	typedef struct packed {
		logic reg_write;
		logic mem_to_reg;
	} wb_ctrl_t;

	// one decoded instruction from decode
	typedef struct packed {
		logic [data_w-1:0]    pc;      // next pc, word addressed
		logic [data_w-1:0]    reg1;    // rs value from regfile
		logic [data_w-1:0]    reg2;    // rt value from regfile
		logic [data_w-1:0]    imm;     // already sign extended
		logic [reg_idx_w-1:0] rs;
		logic [reg_idx_w-1:0] rt;
		logic [reg_idx_w-1:0] rd;
		logic [reg_idx_w-1:0] shamt;
		ex_ctrl_t             ex;
		mem_ctrl_t            mem;
		wb_ctrl_t             wb;
		logic                 halt;
	} ex_req_t;

	// bypass from a later stage
	typedef struct packed {
		logic                 write_en;
		logic [reg_idx_w-1:0] dest;
		logic [data_w-1:0]    value;
	} fwd_src_t;

	// handed to the memory stage
	typedef struct packed {
		logic [data_w-1:0]    branch_target;
		logic [data_w-1:0]    alu_result;
		logic                 zero;
		logic [data_w-1:0]    store_data;
		logic [reg_idx_w-1:0] write_reg;
		mem_ctrl_t            mem;
		wb_ctrl_t             wb;
		logic                 halt;
	} ex_result_t;

endpackage

// File: src/operand_forward.sv
`timescale 1ns/10ps

module operand_forward (
	input  mips_ex_pkg::ex_req_t              req,
	input  mips_ex_pkg::fwd_src_t             fwd_mem,     // instr now in mem
	input  mips_ex_pkg::fwd_src_t             fwd_wb,      // instr now in wb
	output logic [mips_ex_pkg::data_w-1:0]    op_a,
	output logic [mips_ex_pkg::data_w-1:0]    op_b,
	output logic [mips_ex_pkg::data_w-1:0]    store_data
);
	import mips_ex_pkg::*;

	logic [data_w-1:0] rs_val;   // rs after bypass
	logic [data_w-1:0] rt_val;   // rt after bypass
	logic [data_w-1:0] shamt_ext;

	// does this source write the register we read
	function automatic logic hits(input fwd_src_t src, input logic [reg_idx_w-1:0] idx);
		return src.write_en && (src.dest != '0) && (src.dest == idx);
	endfunction

	// mem is younger than wb, so it wins
	function automatic logic [data_w-1:0] bypass(
		input logic [reg_idx_w-1:0] idx,
		input logic [data_w-1:0]    reg_val,
		input fwd_src_t             src_mem,
		input fwd_src_t             src_wb
	);
		logic [data_w-1:0] val;
		if (hits(src_mem, idx))
		begin
			val = src_mem.value;
		end
		else if (hits(src_wb, idx))
		begin
			val = src_wb.value;
		end
		else
		begin
			val = reg_val;   // no hazard, regfile value is current
		end
		return val;
	endfunction

	//////////////////////////////
	// forwarding
	//////////////////////////////

	assign rs_val = bypass(req.rs, req.reg1, fwd_mem, fwd_wb);
	assign rt_val = bypass(req.rt, req.reg2, fwd_mem, fwd_wb);

	assign shamt_ext = {{(data_w-reg_idx_w){1'b0}}, req.shamt};

	//////////////////////////////
	// operand select
	//////////////////////////////

	always_comb
	begin
		// a side: link pc, shift amount or rs
		if (req.ex.link)
			op_a = req.pc;
		else if (req.ex.use_shamt)
			op_a = shamt_ext;
		else
			op_a = rs_val;

		// b side: pc + 1 for link, else imm or rt
		if (req.ex.link)
			op_b = {{(data_w-1){1'b0}}, 1'b1};
		else if (req.ex.use_imm)
			op_b = req.imm;
		else
			op_b = rt_val;
	end

	assign store_data = rt_val;   // sw always stores rt

	// decode never asks for both a-side overrides at once
	always_comb
	begin
		assert final (!(req.ex.link === 1'b1 && req.ex.use_shamt === 1'b1))
			else $error("operand_forward: link and use_shamt both set");
	end

endmodule

// File: verif/ex_stage_tb.sv
`timescale 1ns/10ps

module ex_stage_tb;
	import mips_ex_pkg::*;

	localparam int num_requests = 3000;
	localparam int accept_limit = 64;   // cycles per request before giving up
	localparam int drain_limit  = 16;

	logic       clk;
	logic       reset;
	ex_req_t    in_req;
	logic       in_valid;
	logic       in_ready;
	fwd_src_t   fwd_mem;
	fwd_src_t   fwd_wb;
	logic       flush;
	ex_result_t out_res;
	logic       out_valid;
	logic       out_ready;

	ex_result_t exp_q[$];   // accepted, not yet handed to mem
	ex_result_t held_res;   // out_res seen during a stall
	logic       was_stalled;
	int         value_errors;
	int         protocol_errors;
	int         timeouts;
	int         checked;

	ex_stage uut (
		.clk       (clk),
		.reset     (reset),
		.in_req    (in_req),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.fwd_mem   (fwd_mem),
		.fwd_wb    (fwd_wb),
		.flush     (flush),
		.out_res   (out_res),
		.out_valid (out_valid),
		.out_ready (out_ready)
	);

	always #4 clk = ~clk;   // 8 ns period

	//////////////////////////////
	// reference model
	//////////////////////////////

	// register 0 is hardwired, never bypassed
	function automatic logic [31:0] forwarded(input logic [4:0] idx, input logic [31:0] reg_val,
		input fwd_src_t fm, input fwd_src_t fw);
		if (idx != 5'd0 && fm.write_en && fm.dest == idx)
			return fm.value;   // youngest producer
		if (idx != 5'd0 && fw.write_en && fw.dest == idx)
			return fw.value;
		return reg_val;
	endfunction

	function automatic logic [31:0] alu_model(input alu_op_t op, input logic [31:0] a,
		input logic [31:0] b);
		logic [4:0]  s;
		logic [31:0] r;
		s = a[4:0];
		case (op)
			alu_add:  r = a + b;
			alu_sub:  r = a + ~b + 32'd1;   // two's complement
			alu_and:  r = a & b;
			alu_or:   r = a | b;
			alu_xor:  r = a ^ b;
			alu_nor:  r = ~(a | b);
			alu_slt:  r = (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
			alu_sltu: r = {31'b0, a < b};
			alu_sll:  r = b << s;
			alu_srl:  r = b >> s;
			alu_sra:  r = (b >> s) | (b[31] ? ~(32'hffff_ffff >> s) : 32'h0);   // fill with sign
			alu_lui:  r = {b[15:0], 16'h0};
			default:  r = 32'h0;
		endcase
		return r;
	endfunction

	function automatic ex_result_t expected_result(input ex_req_t r, input fwd_src_t fm,
		input fwd_src_t fw);
		ex_result_t  e;
		logic [31:0] rs_v;
		logic [31:0] rt_v;
		logic [31:0] a;
		logic [31:0] b;
		rs_v = forwarded(r.rs, r.reg1, fm, fw);
		rt_v = forwarded(r.rt, r.reg2, fm, fw);
		a = r.ex.link ? r.pc : (r.ex.use_shamt ? {27'b0, r.shamt} : rs_v);
		b = r.ex.link ? 32'd1 : (r.ex.use_imm ? r.imm : rt_v);
		e.alu_result    = alu_model(r.ex.alu_op, a, b);
		e.zero          = (e.alu_result == 32'h0);
		e.store_data    = rt_v;
		e.branch_target = r.pc + r.imm;
		e.write_reg     = r.ex.link ? 5'(link_reg) : (r.ex.dst_rd ? r.rd : r.rt);
		e.mem           = r.mem;
		e.wb            = r.wb;
		e.halt          = r.halt;
		return e;
	endfunction

	//////////////////////////////
	// stimulus
	//////////////////////////////

	// small index range so hazards are common
	function automatic ex_req_t random_request();
		ex_req_t     r;
		logic [15:0] imm16;
		imm16 = 16'($urandom);
		r.pc = $urandom;
		r.reg1 = $urandom;
		r.reg2 = ($urandom_range(0, 3) == 0) ? r.reg1 : $urandom;   // equal operands hit zero
		r.imm = {{16{imm16[15]}}, imm16};
		r.rs = 5'($urandom_range(0, 3));
		r.rt = 5'($urandom_range(0, 3));
		r.rd = 5'($urandom_range(0, 3));
		r.shamt = 5'($urandom);
		r.ex.alu_op = alu_op_t'($urandom_range(0, 15));   // 12..15 unused codes
		r.ex.link = ($urandom_range(0, 7) == 0);
		r.ex.use_shamt = r.ex.link ? 1'b0 : 1'($urandom_range(0, 1));
		r.ex.use_imm = 1'($urandom_range(0, 1));
		r.ex.dst_rd = 1'($urandom_range(0, 1));
		r.mem = 9'($urandom);
		r.wb = 2'($urandom);
		r.halt = ($urandom_range(0, 15) == 0);
		return r;
	endfunction

	task automatic vary_side_inputs();
		fwd_mem.write_en = 1'($urandom);
		fwd_mem.dest     = 5'($urandom_range(0, 3));
		fwd_mem.value    = $urandom;
		fwd_wb.write_en  = 1'($urandom);
		fwd_wb.dest      = 5'($urandom_range(0, 3));
		fwd_wb.value     = $urandom;
		out_ready        = ($urandom_range(0, 9) < 7);
		flush            = ($urandom_range(0, 19) == 0);   // rare
	endtask

	// hold the request until a handshake edge
	task automatic wait_for_accept();
		int   waited;
		logic took;
		waited = 0;
		took = 1'b0;
		while (!took && waited < accept_limit)
		begin
			vary_side_inputs();
			@(negedge clk);
			took = ((in_valid && in_ready) === 1'b1);
			@(posedge clk);
			#1;
			waited++;
		end
		if (!took)
		begin
			$display("timeout: request not accepted within %0d cycles", accept_limit);
			timeouts++;
		end
	endtask

	task automatic drain_pipeline();
		int waited;
		in_valid = 1'b0;
		flush = 1'b0;
		out_ready = 1'b1;
		waited = 0;
		while (out_valid !== 1'b0 && waited < drain_limit)
		begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (out_valid !== 1'b0)
		begin
			$display("timeout: last result never left the stage");
			timeouts++;
		end
	endtask

	//////////////////////////////
	// checking
	//////////////////////////////

	task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp)
		else
		begin
			$display("FAILED time %0t %s expected %h actual %h", $time, name, exp, act);
			value_errors++;
		end
	endtask

	task automatic compare_result(input ex_result_t e, input ex_result_t a);
		check_field("branch_target", e.branch_target, a.branch_target);
		check_field("alu_result", e.alu_result, a.alu_result);
		check_field("zero", 32'(e.zero), 32'(a.zero));
		check_field("store_data", e.store_data, a.store_data);
		check_field("write_reg", 32'(e.write_reg), 32'(a.write_reg));
		check_field("mem", 32'(e.mem), 32'(a.mem));
		check_field("wb", 32'(e.wb), 32'(a.wb));
		check_field("halt", 32'(e.halt), 32'(a.halt));
	endtask

	// inputs and outputs are both settled at the falling edge
	always @(negedge clk)
	begin
		if (!reset)
		begin
			assert (out_valid === (exp_q.size() != 0))   // one cycle latency, nothing lost
			else
			begin
				$display("FAILED time %0t out_valid expected %0d actual %b", $time,
					exp_q.size() != 0, out_valid);
				protocol_errors++;
			end
			assert (in_ready === (exp_q.size() == 0 || out_ready))   // free slot or leaving now
			else
			begin
				$display("FAILED time %0t in_ready expected %0d actual %b", $time,
					exp_q.size() == 0 || out_ready, in_ready);
				protocol_errors++;
			end
			if (was_stalled && out_valid === 1'b1)
				compare_result(held_res, out_res);   // must hold under back-pressure
			if (out_valid === 1'b1 && exp_q.size() != 0)
				compare_result(exp_q[0], out_res);
			was_stalled = (out_valid === 1'b1) && !out_ready && !flush;
			held_res = out_res;
			if (out_valid === 1'b1 && out_ready && exp_q.size() != 0)
			begin
				void'(exp_q.pop_front());
				checked++;
			end
			if (flush)
				exp_q.delete();   // in-flight and offered items both dropped
			else if (in_valid && in_ready === 1'b1)
				exp_q.push_back(expected_result(in_req, fwd_mem, fwd_wb));
		end
	end

	//////////////////////////////
	// main sequence
	//////////////////////////////

	initial
	begin
		void'($urandom(45));
		clk = 1'b0;
		reset = 1'b1;
		in_req = '0;
		in_valid = 1'b0;
		fwd_mem = '0;
		fwd_wb = '0;
		flush = 1'b0;
		out_ready = 1'b0;
		was_stalled = 1'b0;
		held_res = '0;
		value_errors = 0;
		protocol_errors = 0;
		timeouts = 0;
		checked = 0;
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
		@(negedge clk);
		check_field("out_valid after reset", 32'h0, 32'(out_valid));
		check_field("out_res.alu_result after reset", 32'h0, out_res.alu_result);
		check_field("out_res.write_reg after reset", 32'h0, 32'(out_res.write_reg));
		@(posedge clk);
		#1;
		for (int n = 0; n < num_requests; n++)
		begin
			in_valid = 1'b0;
			repeat ($urandom_range(0, 2))   // idle gap
			begin
				vary_side_inputs();
				@(posedge clk);
				#1;
			end
			in_req = random_request();
			in_valid = 1'b1;
			wait_for_accept();
			if (timeouts != 0)
				break;
		end
		in_valid = 1'b0;
		drain_pipeline();
		if (exp_q.size() != 0)
		begin
			$display("results still expected after the stage drained: %0d", exp_q.size());
			protocol_errors++;
		end
		$display("value errors %0d, protocol errors %0d, timeouts %0d, results checked %0d",
			value_errors, protocol_errors, timeouts, checked);
		if (value_errors == 0 && protocol_errors == 0 && timeouts == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule
